// ==== hdl/dac_pkg.sv ====
// shared types for the DAC output path
// sample, scale, product and word types, plus the lane count and sample limits
`default_nettype none

package dac_pkg;

  // number of samples carried in one parallel word
  localparam int lanes = 4;

  // widths of the sample and the fixed-point scale factor
  localparam int sample_width = 16;
  localparam int scale_width = 18;

  // one signed DAC sample
  typedef logic signed [sample_width-1:0] sample_t;

  // signed fixed-point scale, the fraction bits are set by the top level
  typedef logic signed [scale_width-1:0] scale_t;

  // full product of a sample and a scale, wide enough that it never overflows
  typedef logic signed [sample_width+scale_width-1:0] product_t;

  // a word of lanes, lane 0 sits in the low bits
  typedef sample_t [lanes-1:0] dac_word_t;

  // saturation limits for a scaled sample
  localparam sample_t sample_max = 16'sh7fff;
  localparam sample_t sample_min = 16'sh8000;

endpackage

`default_nettype wire

// ==== hdl/dac_prescaler.sv ====
// two-stage prescaler for the DAC output path
// multiplies every lane by a signed scale, then shifts right and saturates
`timescale 1ns/1ps
`default_nettype none

module dac_prescaler #(
  parameter int scale_frac_bits = 16
) (
  input  wire                clk,
  input  wire                reset,
  input  wire dac_pkg::dac_word_t in_word,
  input  wire                in_valid,
  output logic               in_ready,
  input  wire dac_pkg::scale_t    scale,
  output dac_pkg::dac_word_t scaled_word,
  output logic               scaled_valid,
  input  wire                scaled_ready
);

  // stage 1 holds the full-width product of every lane
  dac_pkg::product_t [dac_pkg::lanes-1:0] s1_prod;
  logic                                   s1_valid;

  // combinational values that feed the two stages
  dac_pkg::product_t [dac_pkg::lanes-1:0] prod_next;
  dac_pkg::dac_word_t                     sat_word;

  // both stages move together, so under back-pressure they simply hold
  logic advance;

  // the pipeline may move when the output stage is empty or is being taken
  assign advance = !scaled_valid || scaled_ready;

  // stage 1 can take a new word whenever the pipeline moves
  assign in_ready = advance;

  // signed multiply per lane, both operands are sign-extended to the product width
  always_comb begin
    for (int i = 0; i < dac_pkg::lanes; i++) begin
      prod_next[i] = dac_pkg::product_t'($signed(in_word[i])) * dac_pkg::product_t'(scale);
    end
  end

  // arithmetic shift floors toward minus infinity, then the result is clamped
  // to the sample range before it is narrowed
  always_comb begin
    dac_pkg::product_t shifted;
    shifted = '0;
    for (int i = 0; i < dac_pkg::lanes; i++) begin
      shifted = s1_prod[i] >>> scale_frac_bits;
      if (shifted > dac_pkg::product_t'(dac_pkg::sample_max)) begin
        sat_word[i] = dac_pkg::sample_max;
      end else if (shifted < dac_pkg::product_t'(dac_pkg::sample_min)) begin
        sat_word[i] = dac_pkg::sample_min;
      end else begin
        sat_word[i] = dac_pkg::sample_t'(shifted);
      end
    end
  end

  // valid bits of both stages
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid     <= 1'b0;
      scaled_valid <= 1'b0;
    end else if (advance) begin
      s1_valid     <= in_valid;
      scaled_valid <= s1_valid;
    end
  end

  // payload of both stages, it only matters where the matching valid is set
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_prod     <= prod_next;
      scaled_word <= sat_word;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
// synchronous FIFO of scaled DAC words
// valid/ready on both the write and the read side
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
  parameter int fifo_depth = 8
) (
  input  wire                clk,
  input  wire                reset,
  input  wire dac_pkg::dac_word_t wr_word,
  input  wire                wr_valid,
  output logic               wr_ready,
  output dac_pkg::dac_word_t rd_word,
  output logic               rd_valid,
  input  wire                rd_ready
);

  // fifo_depth must be a power of two and at least 2
  localparam int addr_w = $clog2(fifo_depth);

  // pointers carry one extra wrap bit so full and empty differ
  typedef logic [addr_w:0] ptr_t;

  dac_pkg::dac_word_t mem [fifo_depth];
  ptr_t               wr_ptr;
  ptr_t               rd_ptr;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign empty = wr_ptr == rd_ptr;

  // same address but a different wrap bit means the writer is a full lap ahead
  assign full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

  // a write while full is refused, even if a read happens in the same cycle
  assign wr_ready = !full;
  assign rd_valid = !empty;

  assign wr_en = wr_valid && wr_ready;
  assign rd_en = rd_valid && rd_ready;

  // the head word is read straight from storage
  assign rd_word = mem[rd_ptr[addr_w-1:0]];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[addr_w-1:0]] <= wr_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dac_serializer.sv ====
// word to sample serializer for the DAC port
// holds one word and hands out its lanes from 0 upward
`timescale 1ns/1ps
`default_nettype none

module dac_serializer (
  input  wire                clk,
  input  wire                reset,
  input  wire dac_pkg::dac_word_t word,
  input  wire                word_valid,
  output logic               word_ready,
  output dac_pkg::sample_t   dac_sample,
  output logic               dac_valid,
  input  wire                dac_ready
);

  // counter wide enough to index every lane
  localparam int lane_w = (dac_pkg::lanes > 1) ? $clog2(dac_pkg::lanes) : 1;

  dac_pkg::dac_word_t hold_word;
  logic [lane_w-1:0]  lane_cnt;
  logic               busy;

  logic last_lane;
  logic take;
  logic fire;

  assign last_lane = lane_cnt == lane_w'(dac_pkg::lanes - 1);
  assign fire      = dac_valid && dac_ready;

  // a new word is taken when idle, or as the last lane leaves so words stream
  // back to back without a bubble
  assign word_ready = !busy || (fire && last_lane);
  assign take       = word_valid && word_ready;

  assign dac_valid  = busy;
  assign dac_sample = hold_word[lane_cnt];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      lane_cnt <= '0;
    end else if (take) begin
      // restart at lane 0 with the incoming word
      busy     <= 1'b1;
      lane_cnt <= '0;
    end else if (fire) begin
      lane_cnt <= lane_cnt + 1'b1;
      if (last_lane) begin
        busy <= 1'b0;
      end
    end
  end

  // the word is only loaded on a take, so the sample holds under back-pressure
  always_ff @(posedge clk) begin
    if (take) begin
      hold_word <= word;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dac_output_path.sv ====
// top level of the DAC output path
// prescaler, then word FIFO, then serializer to the DAC port
`timescale 1ns/1ps
`default_nettype none

module dac_output_path #(
  parameter int scale_frac_bits = 16,
  parameter int fifo_depth      = 8
) (
  input  wire                clk,
  input  wire                reset,
  input  wire dac_pkg::dac_word_t in_word,
  input  wire                in_valid,
  output logic               in_ready,
  input  wire dac_pkg::scale_t    scale,
  output dac_pkg::sample_t   dac_sample,
  output logic               dac_valid,
  input  wire                dac_ready
);

  // prescaler to FIFO link
  dac_pkg::dac_word_t scaled_word;
  logic               scaled_valid;
  logic               scaled_ready;

  // FIFO to serializer link
  dac_pkg::dac_word_t fifo_word;
  logic               fifo_valid;
  logic               fifo_ready;

  // scale is a level, it should only change while no words are accepted
  dac_prescaler #(
    .scale_frac_bits(scale_frac_bits)
  ) prescaler_i (
    .clk          (clk),
    .reset        (reset),
    .in_word      (in_word),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .scale        (scale),
    .scaled_word  (scaled_word),
    .scaled_valid (scaled_valid),
    .scaled_ready (scaled_ready)
  );

  sample_fifo #(
    .fifo_depth(fifo_depth)
  ) fifo_i (
    .clk      (clk),
    .reset    (reset),
    .wr_word  (scaled_word),
    .wr_valid (scaled_valid),
    .wr_ready (scaled_ready),
    .rd_word  (fifo_word),
    .rd_valid (fifo_valid),
    .rd_ready (fifo_ready)
  );

  dac_serializer serializer_i (
    .clk        (clk),
    .reset      (reset),
    .word       (fifo_word),
    .word_valid (fifo_valid),
    .word_ready (fifo_ready),
    .dac_sample (dac_sample),
    .dac_valid  (dac_valid),
    .dac_ready  (dac_ready)
  );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
// clock and reset source for the testbench
// 40 ns clock, synchronous reset held for a number of rising edges
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
  end

  always #(period_ns / 2) clk = ~clk;

  // reset drops on a rising edge, like any other synchronous input
  initial begin
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/dac_output_path_asserts.sv ====
// protocol assertions for the DAC output path, bound to its top level
// reset state, no sample before the first word, and a stable DAC port under back-pressure
`timescale 1ns/1ps
`default_nettype none

module dac_output_path_asserts (
  input wire                   clk,
  input wire                   reset,
  input wire                   in_valid,
  input wire                   in_ready,
  input wire dac_pkg::sample_t dac_sample,
  input wire                   dac_valid,
  input wire                   dac_ready
);

  // number of failed assertions, the testbench watches it
  int failures;

  // high once the path has taken its first word
  logic word_seen;

  initial failures = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      word_seen <= 1'b0;
    end else if (in_valid && in_ready) begin
      word_seen <= 1'b1;
    end
  end

  // the path leaves reset empty and ready for a word
  reset_state: assert property (@(posedge clk) reset |=> in_ready && !dac_valid)
    else begin
      $error("in_ready low or dac_valid high right after reset");
      failures = failures + 1;
    end

  // nothing may reach the DAC before a word went in
  no_early_sample: assert property (@(posedge clk) disable iff (reset)
    !word_seen |-> !dac_valid)
    else begin
      $error("dac_valid rose before any word was accepted");
      failures = failures + 1;
    end

  // a stalled sample stays on the port unchanged until it is taken
  hold_sample: assert property (@(posedge clk) disable iff (reset)
    dac_valid && !dac_ready |=> dac_valid && $stable(dac_sample))
    else begin
      $error("dac_sample changed or dac_valid dropped while dac_ready was low");
      failures = failures + 1;
    end

endmodule

`default_nettype wire

// ==== bench/dac_output_path_tb.sv ====
// testbench for the DAC output path
// random words with gaps and back-pressure, a queue of expected samples and checking assertions
`timescale 1ns/1ps
`default_nettype none

module dac_output_path_tb;

  localparam int scale_frac_bits = 16;
  localparam int fifo_depth      = 8;
  // roughly twice the cycles that the stimulus below takes
  localparam int max_cycles      = 4000;

  logic               clk;
  logic               reset;
  dac_pkg::dac_word_t in_word;
  logic               in_valid;
  logic               in_ready;
  dac_pkg::scale_t    scale;
  dac_pkg::sample_t   dac_sample;
  logic               dac_valid;
  logic               dac_ready;

  // expected samples in the order the DAC port has to present them
  dac_pkg::sample_t exp_q[$];
  int               exp_count = 0;
  dac_pkg::sample_t exp_head  = '0;

  // handshakes seen at the falling edge, they take effect at the next rising edge
  logic               accept_n   = 1'b0;
  logic               transfer_n = 1'b0;
  logic               drained_n  = 1'b0;
  logic               saw_stall  = 1'b0;
  dac_pkg::dac_word_t accept_word;
  dac_pkg::scale_t    accept_scale;

  logic [31:0] rng_state = 32'd22603;
  int          cycles    = 0;

  clock_gen #(.period_ns(40), .reset_cycles(8)) clock_i (.clk(clk), .reset(reset));

  dac_output_path #(
    .scale_frac_bits(scale_frac_bits),
    .fifo_depth     (fifo_depth)
  ) DUT (
    .clk(clk), .reset(reset),
    .in_word(in_word), .in_valid(in_valid), .in_ready(in_ready), .scale(scale),
    .dac_sample(dac_sample), .dac_valid(dac_valid), .dac_ready(dac_ready)
  );

  bind dac_output_path dac_output_path_asserts asserts_i (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
    .dac_sample(dac_sample), .dac_valid(dac_valid), .dac_ready(dac_ready)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // scaling rule: signed product, floor by the fraction bits, clamp to 16 bits
  function automatic dac_pkg::sample_t expected_lane(input dac_pkg::sample_t s,
                                                     input dac_pkg::scale_t k);
    longint p;
    p = longint'(s) * longint'(k);
    p = p >>> scale_frac_bits;
    if (p > 64'sd32767) begin
      return 16'sh7fff;
    end
    if (p < -64'sd32768) begin
      return 16'sh8000;
    end
    return dac_pkg::sample_t'(p);
  endfunction

  // full-scale words mix both rails with random samples
  function automatic dac_pkg::dac_word_t make_word(input bit full_scale);
    dac_pkg::dac_word_t w;
    logic [31:0]        r;
    for (int i = 0; i < dac_pkg::lanes; i++) begin
      r = next_rand();
      if (!full_scale || r[1:0] == 2'd3) begin
        w[i] = dac_pkg::sample_t'(r[31:16]);
      end else if (r[1:0] == 2'd0) begin
        w[i] = 16'sh7fff;
      end else if (r[1:0] == 2'd1) begin
        w[i] = 16'sh8000;
      end else begin
        w[i] = 16'sh8001;
      end
    end
    return w;
  endfunction

  // one rising edge; dac_ready is held high or is high about half the time
  task automatic next_edge(input bit random_ready);
    @(posedge clk);
    if (random_ready) begin
      dac_ready <= (next_rand() % 32'd100) < 32'd50;
    end else begin
      dac_ready <= 1'b1;
    end
  endtask

  // a word stays on in_word until it is taken, then a gap may follow
  task automatic send_words(input int count, input int gap_pct, input bit full_scale,
                            input bit random_ready);
    int issued;
    int done;
    issued = 0;
    done   = 0;
    while (done < count) begin
      next_edge(random_ready);
      if (accept_n) begin
        done++;
      end
      if (accept_n || !in_valid) begin
        if (issued < count && (next_rand() % 32'd100) >= 32'(gap_pct)) begin
          in_word  <= make_word(full_scale);
          in_valid <= 1'b1;
          issued++;
        end else begin
          in_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic wait_drain();
    do begin
      next_edge(1'b0);
    end while (!drained_n);
  endtask

  always @(negedge clk) begin
    accept_n     = !reset && in_valid && in_ready;
    transfer_n   = !reset && dac_valid && dac_ready;
    accept_word  = in_word;
    accept_scale = scale;
    drained_n    = !in_valid && in_ready && !dac_valid && exp_q.size() == 0;
    if (!reset && in_valid && !in_ready) begin
      saw_stall = 1'b1;
    end
  end

  // reference model, lanes go in from 0 upward as each word is accepted
  always @(posedge clk) begin
    if (transfer_n && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    if (accept_n) begin
      for (int i = 0; i < dac_pkg::lanes; i++) begin
        exp_q.push_back(expected_lane(accept_word[i], accept_scale));
      end
    end
    exp_count = exp_q.size();
    exp_head  = (exp_count > 0) ? exp_q[0] : '0;
  end

  // outputs are compared at the falling edge, where they are settled
  sample_expected: assert property (@(negedge clk) disable iff (reset)
    dac_valid |-> exp_count > 0)
    else abort_run($sformatf("dac_valid high at %0t ns with no sample expected", $time));

  sample_value: assert property (@(negedge clk) disable iff (reset)
    dac_valid && exp_count > 0 |-> dac_sample == exp_head)
    else abort_run($sformatf("mismatch at %0t ns: dac_sample %0d, expected %0d",
                             $time, dac_sample, exp_head));

  always @(negedge clk) begin
    if (DUT.asserts_i.failures != 0) begin
      abort_run("a protocol assertion on the DUT ports failed");
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      abort_run($sformatf("timeout: the run did not finish within %0d cycles", max_cycles));
    end
  end

  initial begin
    logic [31:0] r;
    in_word   = '0;
    in_valid  = 1'b0;
    scale     = '0;
    dac_ready = 1'b0;
    do begin
      @(negedge clk);
    end while (reset);
    // a quiet stretch first, no sample may show up yet
    repeat (6) next_edge(1'b0);
    // steady flow, scales of at most 1.0 in magnitude and of either sign
    repeat (6) begin
      r = next_rand();
      scale <= dac_pkg::scale_t'($signed(r[16:0]));
      send_words(12, 0, 1'b0, 1'b0);
    end
    // scales at and near the 18-bit limits drive full-scale samples into the rails
    scale <= 18'sh1ffff;
    send_words(8, 0, 1'b1, 1'b0);
    scale <= 18'sh20000;
    send_words(8, 0, 1'b1, 1'b0);
    scale <= 18'sh1c000;
    send_words(8, 0, 1'b1, 1'b0);
    scale <= 18'sh24000;
    send_words(8, 0, 1'b1, 1'b0);
    // gaps in in_valid, any scale in the 18-bit range
    repeat (4) begin
      r = next_rand();
      scale <= dac_pkg::scale_t'(r[17:0]);
      send_words(16, 40, 1'b0, 1'b0);
    end
    // random dac_ready fills the FIFO and the pipeline until in_ready falls
    repeat (3) begin
      r = next_rand();
      scale <= dac_pkg::scale_t'($signed(r[16:0]));
      send_words(24, 10, 1'b0, 1'b1);
    end
    wait_drain();
    if (saw_stall) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("in_ready never fell although the DAC port was stalled");
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/dac_pkg.sv
hdl/dac_prescaler.sv
hdl/sample_fifo.sv
hdl/dac_serializer.sv
hdl/dac_output_path.sv
bench/clock_gen.sv
bench/dac_output_path_asserts.sv
bench/dac_output_path_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the DAC output path testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dac_output_path_tb -f compile.f \
  --Mdir obj_dir -o dac_output_path_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

# protocol assertions report with $error, the testbench then ends the run itself
./obj_dir/dac_output_path_sim +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
exit 0
